/* hw/rv_pkg.sv */
/*
 * RV32I core shared definitions
 * Widths, opcode and funct3 codes, ALU and writeback select codes,
 * and the instruction word with its format views
 */
package rv_pkg;

	parameter int XLEN       = 32;
	parameter int PC_W       = 12; // Byte PC, 4 KiB program space
	parameter int REG_W      = 5;
	parameter int CON_ADDR_W = 11; // Host word address

	// Major opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_OPIMM  = 7'b0010011;
	localparam logic [6:0] OP_OP     = 7'b0110011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;
	localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

	localparam logic [6:0] F7_ALT = 7'b0100000; // SUB and SRA

	// funct3, ALU group
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_WORD = 3'b010; // LW and SW
	// funct3, branch group
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;

	localparam logic [3:0] ALU_ADD   = 4'd0;
	localparam logic [3:0] ALU_SUB   = 4'd1;
	localparam logic [3:0] ALU_AND   = 4'd2;
	localparam logic [3:0] ALU_OR    = 4'd3;
	localparam logic [3:0] ALU_XOR   = 4'd4;
	localparam logic [3:0] ALU_SLT   = 4'd5;
	localparam logic [3:0] ALU_SLTU  = 4'd6;
	localparam logic [3:0] ALU_SLL   = 4'd7;
	localparam logic [3:0] ALU_SRL   = 4'd8;
	localparam logic [3:0] ALU_SRA   = 4'd9;
	localparam logic [3:0] ALU_PASSB = 4'd10; // LUI

	localparam logic [1:0] WB_ALU  = 2'd0;
	localparam logic [1:0] WB_LOAD = 2'd1;
	localparam logic [1:0] WB_PC4  = 2'd2;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// One fetched word, read through whichever format the opcode implies
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		j_fmt_t j;
		u_fmt_t u;
	} instr_t;

endpackage

/* hw/fetch_stage.sv */
/*
 * Fetch stage
 * PC, word-addressed instruction memory loaded by the host port,
 * and the IF/ID register
 */
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
	parameter int IMEM_WORDS = 256
) (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  run,
	input  logic                  stall,     // Load-use hold from decode
	input  logic                  redirect,  // Taken branch or JAL in execute
	input  logic [PC_W-1:0]       target,
	input  logic [3:0]            con_write,
	input  logic                  con_imem,
	input  logic [CON_ADDR_W-1:0] con_addr,
	input  logic [XLEN-1:0]       con_in,
	output logic                  if_valid,
	output logic [PC_W-1:0]       if_pc,
	output instr_t                if_inst
);

	localparam int IW = $clog2(IMEM_WORDS);

	logic [XLEN-1:0] imem [IMEM_WORDS];
	logic [PC_W-1:0] pc;

	// Host load, whole words only
	always_ff @(posedge CLK) begin
		if (con_imem && con_write == 4'hf)
			imem[con_addr[IW-1:0]] <= con_in;
	end

	// PC and IF/ID valid
	always_ff @(posedge CLK) begin
		if (!rst_n || !run) begin
			pc       <= '0; // Parked at zero until run
			if_valid <= 1'b0;
		end else if (redirect) begin
			pc       <= target;
			if_valid <= 1'b0; // Word fetched this cycle is on the wrong path
		end else if (!stall) begin
			pc       <= pc + PC_W'(4);
			if_valid <= 1'b1;
		end
	end

	// IF/ID payload, frozen during a stall
	always_ff @(posedge CLK) begin
		if (!stall) begin
			if_pc   <= pc;
			if_inst <= imem[pc[IW+1:2]];
		end
	end

endmodule

/* hw/decode_stage.sv */
/*
 * Decode stage
 * Field decode through the format views, immediates, register file
 * with write-through, load-use stall, ECALL stop latch, ID/EX register
 */
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             if_valid,
	input  logic [PC_W-1:0]  if_pc,
	input  instr_t           if_inst,
	input  logic             redirect,
	input  logic             wb_valid,
	input  logic [REG_W-1:0] wb_rd,
	input  logic             wb_reg_write,
	input  logic [XLEN-1:0]  wb_data,
	output logic             stall,
	output logic             id_valid,
	output logic [PC_W-1:0]  id_pc,
	output logic [XLEN-1:0]  id_rs1_val,
	output logic [XLEN-1:0]  id_rs2_val,
	output logic [REG_W-1:0] id_rs1,
	output logic [REG_W-1:0] id_rs2,
	output logic [REG_W-1:0] id_rd,
	output logic [XLEN-1:0]  id_imm,
	output logic [3:0]       id_alu_op,
	output logic             id_use_imm,
	output logic [1:0]       id_wb_sel,
	output logic             id_reg_write,
	output logic             id_is_load,
	output logic             id_is_store,
	output logic             id_is_branch,
	output logic             id_is_jal,
	output logic [2:0]       id_br_funct3,
	output logic             id_halt
);

	logic [XLEN-1:0] regs [32];
	logic            stop; // Sticky after ECALL
	logic            dec_ok, use_rs1, use_rs2, fire, rf_we;
	logic [3:0]      alu_op;
	logic [1:0]      wb_sel;
	logic [XLEN-1:0] imm;
	logic            use_imm, reg_write, is_load, is_store, is_branch, is_jal, is_halt;
	logic [2:0]      f3;
	logic [6:0]      f7;
	logic [REG_W-1:0] rs1, rs2;

	assign f3  = if_inst.r.funct3;
	assign f7  = if_inst.r.funct7;
	assign rs1 = if_inst.r.rs1;
	assign rs2 = if_inst.r.rs2;

	always_comb begin
		dec_ok    = 1'b0; // Unknown opcodes fall out as bubbles
		alu_op    = ALU_ADD;
		use_imm   = 1'b0;
		imm       = {{20{if_inst.i.imm[11]}}, if_inst.i.imm};
		wb_sel    = WB_ALU;
		reg_write = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		is_halt   = 1'b0;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		case (if_inst.r.opcode)
			OP_LUI: begin
				dec_ok    = 1'b1;
				alu_op    = ALU_PASSB;
				use_imm   = 1'b1;
				imm       = {if_inst.u.imm, 12'b0};
				reg_write = 1'b1;
			end
			OP_OPIMM: begin // ADDI only
				dec_ok    = (f3 == F3_ADD);
				use_imm   = 1'b1;
				reg_write = 1'b1;
				use_rs1   = 1'b1;
			end
			OP_OP: begin
				dec_ok    = (f7 == 7'b0) || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SR));
				reg_write = 1'b1;
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
				case (f3)
					F3_ADD:  alu_op = f7[5] ? ALU_SUB : ALU_ADD;
					F3_SLL:  alu_op = ALU_SLL;
					F3_SLT:  alu_op = ALU_SLT;
					F3_SLTU: alu_op = ALU_SLTU;
					F3_XOR:  alu_op = ALU_XOR;
					F3_SR:   alu_op = f7[5] ? ALU_SRA : ALU_SRL;
					F3_OR:   alu_op = ALU_OR;
					default: alu_op = ALU_AND;
				endcase
			end
			OP_LOAD: begin // LW only, address = rs1 + imm
				dec_ok    = (f3 == F3_WORD);
				use_imm   = 1'b1;
				wb_sel    = WB_LOAD;
				reg_write = 1'b1;
				is_load   = 1'b1;
				use_rs1   = 1'b1;
			end
			OP_STORE: begin
				dec_ok   = (f3 == F3_WORD);
				use_imm  = 1'b1;
				imm      = {{20{if_inst.s.imm_hi[6]}}, if_inst.s.imm_hi, if_inst.s.imm_lo};
				is_store = 1'b1;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
			end
			OP_BRANCH: begin
				dec_ok    = (f3 == F3_BEQ) || (f3 == F3_BNE) || (f3 == F3_BLT) || (f3 == F3_BGE);
				imm       = {{19{if_inst.b.imm12}}, if_inst.b.imm12, if_inst.b.imm11,
					if_inst.b.imm10_5, if_inst.b.imm4_1, 1'b0};
				is_branch = 1'b1;
				use_rs1   = 1'b1;
				use_rs2   = 1'b1;
			end
			OP_JAL: begin
				dec_ok    = 1'b1;
				imm       = {{11{if_inst.j.imm20}}, if_inst.j.imm20, if_inst.j.imm19_12,
					if_inst.j.imm11, if_inst.j.imm10_1, 1'b0};
				wb_sel    = WB_PC4; // Link value
				reg_write = 1'b1;
				is_jal    = 1'b1;
			end
			OP_SYSTEM: begin
				dec_ok  = (if_inst == ECALL_WORD); // Other SYSTEM words are NOPs
				is_halt = dec_ok;
			end
			default: ;
		endcase
	end

	// Load in ID/EX feeding the word in IF/ID
	assign stall = if_valid && id_valid && id_is_load && (id_rd != '0) &&
		((use_rs1 && rs1 == id_rd) || (use_rs2 && rs2 == id_rd));

	assign fire = if_valid && dec_ok && !stop && !redirect && !stall;

	// Register file, x0 pinned to zero
	assign rf_we = wb_valid && wb_reg_write && (wb_rd != '0);

	always_ff @(posedge CLK) begin
		if (rf_we)
			regs[wb_rd] <= wb_data;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
			stop     <= 1'b0;
		end else begin
			id_valid <= fire; // Bubble on flush, stall, stop or unknown op
			if (fire && is_halt)
				stop <= 1'b1;
		end
	end

	// ID/EX payload, qualified by id_valid
	always_ff @(posedge CLK) begin
		id_pc        <= if_pc;
		id_rs1       <= use_rs1 ? rs1 : '0;
		id_rs2       <= use_rs2 ? rs2 : '0;
		id_rs1_val   <= (rs1 == '0) ? '0 : (rf_we && wb_rd == rs1) ? wb_data : regs[rs1];
		id_rs2_val   <= (rs2 == '0) ? '0 : (rf_we && wb_rd == rs2) ? wb_data : regs[rs2];
		id_rd        <= if_inst.r.rd;
		id_imm       <= imm;
		id_alu_op    <= alu_op;
		id_use_imm   <= use_imm;
		id_wb_sel    <= wb_sel;
		id_reg_write <= reg_write;
		id_is_load   <= is_load;
		id_is_store  <= is_store;
		id_is_branch <= is_branch;
		id_is_jal    <= is_jal;
		id_br_funct3 <= f3;
		id_halt      <= is_halt;
	end

endmodule

/* hw/execute_stage.sv */
/*
 * Execute stage
 * Operand forwarding, ALU, branch and JAL resolution with redirect,
 * and the EX/MEM register
 */
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             id_valid,
	input  logic [PC_W-1:0]  id_pc,
	input  logic [XLEN-1:0]  id_rs1_val,
	input  logic [XLEN-1:0]  id_rs2_val,
	input  logic [REG_W-1:0] id_rs1,
	input  logic [REG_W-1:0] id_rs2,
	input  logic [REG_W-1:0] id_rd,
	input  logic [XLEN-1:0]  id_imm,
	input  logic [3:0]       id_alu_op,
	input  logic             id_use_imm,
	input  logic [1:0]       id_wb_sel,
	input  logic             id_reg_write,
	input  logic             id_is_load,
	input  logic             id_is_store,
	input  logic             id_is_branch,
	input  logic             id_is_jal,
	input  logic [2:0]       id_br_funct3,
	input  logic             id_halt,
	input  logic             wb_valid,
	input  logic [REG_W-1:0] wb_rd,
	input  logic             wb_reg_write,
	input  logic [XLEN-1:0]  wb_data,
	output logic             redirect,
	output logic [PC_W-1:0]  target,
	output logic             ex_valid,
	output logic [XLEN-1:0]  ex_result,
	output logic [XLEN-1:0]  ex_store_data,
	output logic [REG_W-1:0] ex_rd,
	output logic             ex_reg_write,
	output logic             ex_is_load,
	output logic             ex_is_store,
	output logic [1:0]       ex_wb_sel,
	output logic [PC_W-1:0]  ex_pc4,
	output logic             ex_halt
);

	logic [XLEN-1:0] mem_val, op_a, rs2_fwd, op_b, alu_out;
	logic            taken;

	// Value EX/MEM will write back, load data excluded
	assign mem_val = (ex_wb_sel == WB_PC4) ? {{(XLEN-PC_W){1'b0}}, ex_pc4} : ex_result;

	// Youngest producer first: EX/MEM, then MEM/WB, then the register file read
	function automatic logic [XLEN-1:0] fwd(input logic [REG_W-1:0] rs,
		input logic [XLEN-1:0] rf_val);
		if (ex_valid && ex_reg_write && !ex_is_load && ex_rd != '0 && ex_rd == rs)
			return mem_val;
		else if (wb_valid && wb_reg_write && wb_rd != '0 && wb_rd == rs)
			return wb_data;
		else
			return rf_val;
	endfunction

	assign op_a    = fwd(id_rs1, id_rs1_val);
	assign rs2_fwd = fwd(id_rs2, id_rs2_val);
	assign op_b    = id_use_imm ? id_imm : rs2_fwd;

	always_comb begin
		case (id_alu_op)
			ALU_SUB:   alu_out = op_a - op_b;
			ALU_AND:   alu_out = op_a & op_b;
			ALU_OR:    alu_out = op_a | op_b;
			ALU_XOR:   alu_out = op_a ^ op_b;
			ALU_SLT:   alu_out = XLEN'($signed(op_a) < $signed(op_b));
			ALU_SLTU:  alu_out = XLEN'(op_a < op_b);
			ALU_SLL:   alu_out = op_a << op_b[4:0];
			ALU_SRL:   alu_out = op_a >> op_b[4:0];
			ALU_SRA:   alu_out = $signed(op_a) >>> op_b[4:0];
			ALU_PASSB: alu_out = op_b;
			default:   alu_out = op_a + op_b; // ADD, also load/store address
		endcase
	end

	// Branch condition on forwarded register values
	always_comb begin
		case (id_br_funct3)
			F3_BEQ:  taken = (op_a == rs2_fwd);
			F3_BNE:  taken = (op_a != rs2_fwd);
			F3_BLT:  taken = ($signed(op_a) < $signed(rs2_fwd));
			F3_BGE:  taken = ($signed(op_a) >= $signed(rs2_fwd));
			default: taken = 1'b0;
		endcase
	end

	assign redirect = id_valid && ((id_is_branch && taken) || id_is_jal);
	assign target   = id_pc + id_imm[PC_W-1:0]; // PC-relative for both

	always_ff @(posedge CLK) begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= id_valid;
	end

	// EX/MEM payload
	always_ff @(posedge CLK) begin
		ex_result     <= alu_out;
		ex_store_data <= rs2_fwd;
		ex_rd         <= id_rd;
		ex_reg_write  <= id_reg_write;
		ex_is_load    <= id_is_load;
		ex_is_store   <= id_is_store;
		ex_wb_sel     <= id_wb_sel;
		ex_pc4        <= id_pc + PC_W'(4);
		ex_halt       <= id_halt;
	end

endmodule

/* hw/memory_stage.sv */
/*
 * Memory and writeback stage
 * Two-port data memory shared with the host, MEM/WB register,
 * writeback select and the halted flag
 */
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  ex_valid,
	input  logic [XLEN-1:0]       ex_result,
	input  logic [XLEN-1:0]       ex_store_data,
	input  logic [REG_W-1:0]      ex_rd,
	input  logic                  ex_reg_write,
	input  logic                  ex_is_load,
	input  logic                  ex_is_store,
	input  logic [1:0]            ex_wb_sel,
	input  logic [PC_W-1:0]       ex_pc4,
	input  logic                  ex_halt,
	input  logic [3:0]            con_write,
	input  logic                  con_imem,
	input  logic [CON_ADDR_W-1:0] con_addr,
	input  logic [XLEN-1:0]       con_in,
	output logic [XLEN-1:0]       con_out,
	output logic                  wb_valid,
	output logic [REG_W-1:0]      wb_rd,
	output logic                  wb_reg_write,
	output logic [XLEN-1:0]       wb_data,
	output logic                  halted
);

	localparam int DW = $clog2(DMEM_WORDS);

	logic [XLEN-1:0] dmem [DMEM_WORDS];
	logic [DW-1:0]   core_idx;
	logic [XLEN-1:0] load_q, result_q;
	logic [1:0]      sel_q;

	assign core_idx = ex_result[DW+1:2]; // Word address from the ALU

	// Host bytes first, so a core store to the same word lands last
	always_ff @(posedge CLK) begin
		for (int b = 0; b < 4; b++) begin
			if (!con_imem && con_write[b])
				dmem[con_addr[DW-1:0]][8*b +: 8] <= con_in[8*b +: 8];
		end
		if (ex_valid && ex_is_store)
			dmem[core_idx] <= ex_store_data;
	end

	// Synchronous reads on both ports
	always_ff @(posedge CLK) begin
		con_out <= dmem[con_addr[DW-1:0]];
		if (ex_is_load)
			load_q <= dmem[core_idx];
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			halted   <= 1'b0;
		end else begin
			wb_valid <= ex_valid;
			if (ex_valid && ex_halt)
				halted <= 1'b1; // Older stores already written
		end
	end

	// MEM/WB payload
	always_ff @(posedge CLK) begin
		wb_rd        <= ex_rd;
		wb_reg_write <= ex_reg_write;
		sel_q        <= ex_wb_sel;
		result_q     <= (ex_wb_sel == WB_PC4) ? {{(XLEN-PC_W){1'b0}}, ex_pc4} : ex_result;
	end

	assign wb_data = (sel_q == WB_LOAD) ? load_q : result_q;

endmodule

/* hw/riscv_core.sv */
/*
 * Four-stage RV32I core
 * Fetch, decode, execute and memory/writeback, with a host port
 * into both memories
 */
`timescale 1ns/1ps

module riscv_core import rv_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  run,
	input  logic [3:0]            con_write,
	input  logic                  con_imem,  // High selects instruction memory
	input  logic [CON_ADDR_W-1:0] con_addr,
	input  logic [XLEN-1:0]       con_in,
	output logic [XLEN-1:0]       con_out,
	output logic                  halted
);

	// IF/ID
	logic             if_valid;
	logic [PC_W-1:0]  if_pc;
	instr_t           if_inst;
	logic             stall;
	// ID/EX
	logic             id_valid, id_use_imm, id_reg_write, id_is_load, id_is_store;
	logic             id_is_branch, id_is_jal, id_halt;
	logic [PC_W-1:0]  id_pc;
	logic [XLEN-1:0]  id_rs1_val, id_rs2_val, id_imm;
	logic [REG_W-1:0] id_rs1, id_rs2, id_rd;
	logic [3:0]       id_alu_op;
	logic [1:0]       id_wb_sel;
	logic [2:0]       id_br_funct3;
	// Redirect back to fetch and decode
	logic             redirect;
	logic [PC_W-1:0]  target;
	// EX/MEM
	logic             ex_valid, ex_reg_write, ex_is_load, ex_is_store, ex_halt;
	logic [XLEN-1:0]  ex_result, ex_store_data;
	logic [REG_W-1:0] ex_rd;
	logic [1:0]       ex_wb_sel;
	logic [PC_W-1:0]  ex_pc4;
	// MEM/WB, register-file write port
	logic             wb_valid, wb_reg_write;
	logic [REG_W-1:0] wb_rd;
	logic [XLEN-1:0]  wb_data;

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) u_fetch (.*);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) u_memory (.*);

endmodule

/* tests/riscv_core_assertions.sv */
/*
 * Concurrent checks on the core top level
 * Sticky halted, no stores after halt, clean host reads while halted
 */
`timescale 1ns/1ps

module riscv_core_assertions (
	input logic        CLK,
	input logic        rst_n,
	input logic        halted,
	input logic        ex_valid,
	input logic        ex_is_store,
	input logic [10:0] con_addr,
	input logic [31:0] con_out
);

	// Only a reset may clear halted
	halted_sticky: assert property (@(posedge CLK) $fell(halted) |-> !$past(rst_n))
		else $error("halted fell without a reset");

	// Memory stage stays quiet once stopped
	no_store_after_halt: assert property (@(posedge CLK) disable iff (!rst_n)
		halted |-> !(ex_valid && ex_is_store))
		else $error("core store while halted");

	read_known: assert property (@(posedge CLK) disable iff (!rst_n)
		(halted && !$isunknown(con_addr)) |=> !$isunknown(con_out))
		else $error("con_out unknown after a valid host address");

endmodule

bind riscv_core riscv_core_assertions u_checks (.*);

/* tests/tb_riscv_core.sv */
/*
 * Testbench for the four-stage RV32I core
 * Loads programs through the host port, runs to ECALL and checks
 * data memory against values computed here
 */
`timescale 1ns/1ps

module tb_riscv_core;

	localparam logic [31:0] SEED  = 32'hbdeb2ec2;
	localparam logic [31:0] TAPS  = 32'h80200003; // x^32+x^22+x^2+x+1
	localparam logic [31:0] NOP   = 32'h00000013;
	localparam logic [31:0] ECALL = 32'h00000073;

	logic        CLK, rst_n, run, con_imem, halted;
	logic [3:0]  con_write;
	logic [10:0] con_addr;
	logic [31:0] con_in, con_out;
	logic [31:0] lfsr;
	logic [31:0] dm [256];  // Expected data memory
	logic [31:0] prog [$];
	int          errors, checks, timeouts;

	riscv_core uut (
		.CLK(CLK), .rst_n(rst_n), .run(run), .con_write(con_write),
		.con_imem(con_imem), .con_addr(con_addr), .con_in(con_in),
		.con_out(con_out), .halted(halted)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	// Instruction encoders
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] lw(input logic [4:0] rd, input logic [11:0] off);
		return {off, 5'd0, 3'b010, rd, 7'b0000011}; // Base always x0
	endfunction

	function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [11:0] off);
		return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] br(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] fill_word(input int a);
		return 32'h9e370000 ^ {a[7:0], ~a[7:0], a[7:0], 8'h5a}; // Unique per word
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	task automatic emit_li(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800; // Carry cancels the sign of the low part
		prog.push_back(lui(rd, hi[31:12]));
		prog.push_back(addi(rd, rd, v[11:0]));
	endtask

	task automatic host_write(input logic imem, input int a, input logic [3:0] we,
		input logic [31:0] d);
		@(posedge CLK);
		con_imem  <= imem;
		con_addr  <= 11'(a);
		con_in    <= d;
		con_write <= we;
		@(posedge CLK);
		con_write <= 4'h0;
		con_imem  <= 1'b0;
	endtask

	task automatic host_read(input int a, output logic [31:0] d);
		@(posedge CLK);
		con_imem  <= 1'b0;
		con_addr  <= 11'(a);
		con_write <= 4'h0;
		@(posedge CLK);
		@(negedge CLK); // Registered read settled
		d = con_out;
	endtask

	task automatic check_word(input string what, input int k, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERROR %0t: %s word %0d read %h, expected %h",
				$time, what, k, got, exp);
			errors++;
		end
	endtask

	task automatic compare_range(input string what, input int lo, input int hi);
		logic [31:0] got;
		for (int k = lo; k <= hi; k++) begin
			host_read(k, got);
			check_word(what, k, got, dm[k]);
		end
	endtask

	// Reset, then fill both memories with run low
	task automatic setup_core();
		@(posedge CLK);
		rst_n     <= 1'b0;
		run       <= 1'b0;
		con_write <= 4'h0;
		repeat (2) @(posedge CLK);
		rst_n <= 1'b1;
		for (int a = 0; a < 256; a++) begin
			dm[a] = fill_word(a);
			host_write(1'b0, a, 4'hf, dm[a]);
			host_write(1'b1, a, 4'hf, (a < prog.size()) ? prog[a] : NOP);
		end
	endtask

	task automatic run_to_halt(input string what);
		int n;
		n = 0;
		@(posedge CLK);
		run <= 1'b1;
		while (halted !== 1'b1 && n < 4000) begin
			@(negedge CLK);
			n++;
		end
		if (halted !== 1'b1) begin
			$display("Timeout: core never halted on ECALL during %s", what);
			timeouts++;
		end
	endtask

	// Byte enables against the model, run held low
	task automatic host_port_test();
		logic [31:0] a, d, we, got;
		prog.delete();
		setup_core();
		for (int i = 0; i < 40; i++) begin
			take_bits(8, a);
			take_bits(32, d);
			take_bits(4, we);
			host_write(1'b0, a, we[3:0], d);
			for (int b = 0; b < 4; b++)
				if (we[b])
					dm[a][8*b +: 8] = d[8*b +: 8];
			host_read(a, got);
			check_word("host port", a, got, dm[a]);
		end
	endtask

	task automatic alu_chain_test();
		logic [31:0] a, b, imm, u;
		logic [31:0] r [12];
		prog.delete();
		take_bits(32, a);
		take_bits(32, b);
		take_bits(12, imm);
		take_bits(20, u);
		emit_li(1, a);
		emit_li(2, b);
		prog.push_back(r_type(7'h00, 2, 1, 3'd0, 3));  // add x3
		prog.push_back(r_type(7'h20, 1, 3, 3'd0, 4));  // sub x4 = x3-x1
		prog.push_back(r_type(7'h00, 2, 4, 3'd7, 5));  // and
		prog.push_back(r_type(7'h00, 1, 5, 3'd6, 6));  // or
		prog.push_back(r_type(7'h00, 2, 6, 3'd4, 7));  // xor
		prog.push_back(r_type(7'h00, 2, 1, 3'd2, 8));  // slt
		prog.push_back(r_type(7'h00, 1, 2, 3'd3, 9));  // sltu x2<x1
		prog.push_back(r_type(7'h00, 2, 7, 3'd1, 10)); // sll
		prog.push_back(r_type(7'h00, 2, 7, 3'd5, 11)); // srl
		prog.push_back(r_type(7'h20, 2, 1, 3'd5, 12)); // sra
		prog.push_back(addi(13, 12, imm[11:0]));
		prog.push_back(lui(14, u[19:0]));
		// Each result stored straight after it is produced
		for (int k = 0; k < 12; k++)
			prog.insert(5 + 2*k, sw(5'(3 + k), 12'(4*k)));
		prog.push_back(ECALL);
		r[0]  = a + b;
		r[1]  = r[0] - a;
		r[2]  = r[1] & b;
		r[3]  = r[2] | a;
		r[4]  = r[3] ^ b;
		r[5]  = {31'b0, $signed(a) < $signed(b)};
		r[6]  = {31'b0, b < a};
		r[7]  = r[4] << b[4:0];
		r[8]  = r[4] >> b[4:0];
		r[9]  = 32'($signed(a) >>> b[4:0]);
		r[10] = r[9] + {{20{imm[11]}}, imm[11:0]};
		r[11] = {u[19:0], 12'b0};
		setup_core();
		run_to_halt("ALU chain");
		for (int k = 0; k < 12; k++)
			dm[k] = r[k];
		compare_range("ALU chain", 0, 12);
	endtask

	task automatic load_use_test();
		logic [31:0] v0, v1;
		prog.delete();
		take_bits(32, v0);
		take_bits(32, v1);
		emit_li(1, v0);
		prog.push_back(sw(1, 12'd256));
		emit_li(1, v1);
		prog.push_back(sw(1, 12'd260));
		prog.push_back(lw(2, 12'd256));
		prog.push_back(r_type(7'h00, 2, 2, 3'd0, 3)); // Uses x2 at once
		prog.push_back(lw(4, 12'd260));
		prog.push_back(r_type(7'h20, 4, 3, 3'd0, 5));
		prog.push_back(sw(5, 12'd264));
		prog.push_back(lw(6, 12'd264));
		prog.push_back(sw(6, 12'd268)); // Loaded value as store data
		prog.push_back(ECALL);
		setup_core();
		run_to_halt("load-use");
		dm[64] = v0;
		dm[65] = v1;
		dm[66] = 2*v0 - v1;
		dm[67] = dm[66];
		compare_range("load-use", 64, 68);
	endtask

	task automatic branch_test();
		int link;
		prog.delete();
		prog.push_back(addi(1, 0, 12'd5));
		prog.push_back(addi(3, 0, 12'hffd)); // -3
		prog.push_back(addi(4, 0, 12'd7));
		prog.push_back(addi(9, 0, 12'h555)); // Flag value
		prog.push_back(addi(2, 0, 12'd5));   // Forwarded into the BEQ
		prog.push_back(br(3'd0, 1, 2, 13'd12)); // beq taken
		prog.push_back(sw(9, 12'd320));
		prog.push_back(sw(9, 12'd324));
		prog.push_back(br(3'd1, 1, 2, 13'd8));  // bne not taken
		prog.push_back(sw(4, 12'd328));
		prog.push_back(br(3'd1, 1, 3, 13'd12)); // bne taken
		prog.push_back(sw(9, 12'd332));
		prog.push_back(sw(9, 12'd336));
		prog.push_back(br(3'd4, 3, 1, 13'd12)); // blt taken
		prog.push_back(sw(9, 12'd340));
		prog.push_back(sw(9, 12'd344));
		prog.push_back(br(3'd5, 3, 1, 13'd8));  // bge not taken
		prog.push_back(sw(4, 12'd348));
		prog.push_back(br(3'd5, 1, 3, 13'd12)); // bge taken
		prog.push_back(sw(9, 12'd352));
		prog.push_back(sw(9, 12'd356));
		link = 4*prog.size() + 4;
		prog.push_back(jal(10, 21'd12));
		prog.push_back(sw(9, 12'd360));
		prog.push_back(sw(9, 12'd364));
		prog.push_back(sw(10, 12'd368));
		prog.push_back(br(3'd0, 1, 3, 13'd8));  // beq not taken
		prog.push_back(sw(4, 12'd372));
		prog.push_back(ECALL);
		setup_core();
		run_to_halt("branches");
		dm[82] = 32'd7;
		dm[87] = 32'd7;
		dm[92] = 32'(link);
		dm[93] = 32'd7;
		compare_range("branches", 80, 93); // Flagged words keep the fill
	endtask

	task automatic halt_test();
		logic [31:0] v;
		prog.delete();
		take_bits(32, v);
		prog.push_back(addi(0, 0, 12'd99));
		prog.push_back(sw(0, 12'd400));
		prog.push_back(lui(0, 20'habcde));
		prog.push_back(sw(0, 12'd404));
		emit_li(1, v);
		prog.push_back(sw(1, 12'd408));
		prog.push_back(ECALL);
		prog.push_back(sw(1, 12'd412)); // Must never land
		prog.push_back(sw(1, 12'd416));
		setup_core();
		run_to_halt("halt");
		dm[100] = 32'd0;
		dm[101] = 32'd0;
		dm[102] = v;
		compare_range("halt", 100, 104);
		for (int i = 0; i < 20; i++) begin
			@(negedge CLK);
			checks++;
			assert (halted === 1'b1) else begin
				$display("ERROR %0t: halted dropped after ECALL", $time);
				errors++;
			end
		end
	endtask

	initial begin
		rst_n     = 1'b0;
		run       = 1'b0;
		con_write = 4'h0;
		con_imem  = 1'b0;
		con_addr  = '0;
		con_in    = '0;
		lfsr      = SEED;
		errors    = 0;
		checks    = 0;
		timeouts  = 0;
		host_port_test();
		repeat (3) alu_chain_test();
		load_use_test();
		branch_test();
		halt_test();
		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* riscv_core.f */
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/riscv_core.sv
tests/riscv_core_assertions.sv
tests/tb_riscv_core.sv

/* Makefile */
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FLIST     ?= riscv_core.f
BUILD     ?= obj_dir
LOG       ?= sim.log
EXTRA     ?=

VFLAGS := --binary --timing --assert -Wno-fatal $(EXTRA)
SRCS   := $(filter-out +%,$(shell cat $(FLIST)))
BIN    := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
